// ==== all.f ====
+incdir+hw
+incdir+dv
hw/ctl_pkg.sv
hw/cnt_reg_ram.sv
hw/ctl_sequencer.sv
hw/settings_loader.sv
hw/controller_top.sv
dv/controller_tb.sv

// ==== Makefile ====
TOP       ?= controller_tb
VERILATOR ?= verilator
VFLAGS    ?= --assert
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --binary -f all.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(VFLAGS) --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/controller_tb_tasks.svh ====
`ifndef CONTROLLER_TB_TASKS_SVH
`define CONTROLLER_TB_TASKS_SVH

function automatic reg_data_t random_word();
    return reg_data_t'($urandom());
endfunction

// Called and returning on a falling edge
task automatic host_write(input reg_addr_t addr, input reg_data_t data);
    host_req.valid = 1'b1;
    host_req.we    = 1'b1;
    host_req.addr  = addr;
    host_req.data  = data;
    @(negedge CLK);
    host_req = '0;
endtask

task automatic host_read(input reg_addr_t addr, output reg_data_t data);
    host_req.valid = 1'b1;
    host_req.we    = 1'b0;
    host_req.addr  = addr;
    host_req.data  = '0;
    @(negedge CLK);
    host_req = '0;
    repeat (`RAM_RD_LATENCY - 1) @(negedge CLK);
    data = host_rdata;
endtask

task automatic check_data(input string test_name, input reg_data_t expected,
                          input reg_data_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic check_silencer(input string test_name, input silencer_settings_t expected,
                              input silencer_settings_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic check_pwe(input string test_name, input pwe_settings_t expected,
                         input pwe_settings_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic check_outputs(input string test_name, input logic exp_fan,
                             input logic [3:0] exp_gpio);
    check_count++;
    if ({force_fan, gpio_in} !== {exp_fan, exp_gpio}) begin
        error_count++;
        $display("CHECK FAILED %s: expected fan %b gpio %h, actual fan %b gpio %h",
                 test_name, exp_fan, exp_gpio, force_fan, gpio_in);
    end
endtask

// Also notes a pulse of the other group seen during the wait
task automatic wait_update_pulse(input bit pwe_group, input string test_name,
                                 output bit seen, output bit other_seen);
    int    waited;
    string group_name;
    seen       = 1'b0;
    other_seen = 1'b0;
    waited     = 0;
    while (!seen && waited < PULSE_WAIT_CYCLES) begin
        @(negedge CLK);
        waited++;
        seen = pwe_group ? pwe.update : silencer.update;
        if (pwe_group ? silencer.update : pwe.update) begin
            other_seen = 1'b1;
        end
    end
    if (!seen) begin
        if (pwe_group) begin
            group_name = "pulse width encoder";
        end else begin
            group_name = "silencer";
        end
        error_count++;
        $display("ERROR: %s: the %s update pulse never came within %0d cycles",
                 test_name, group_name, PULSE_WAIT_CYCLES);
    end
endtask

task automatic write_silencer_fields(output silencer_settings_t exp);
    reg_data_t mode_word;
    mode_word                      = random_word();
    exp.update                     = 1'b1;
    exp.mode                       = mode_word[0]; // Only bit 0 is kept
    exp.update_rate_intensity      = random_word();
    exp.update_rate_phase          = random_word();
    exp.completion_steps_intensity = random_word();
    exp.completion_steps_phase     = random_word();
    host_write(`ADDR_SILENCER_MODE, mode_word);
    host_write(`ADDR_SILENCER_UPDATE_RATE_INTENSITY, exp.update_rate_intensity);
    host_write(`ADDR_SILENCER_UPDATE_RATE_PHASE, exp.update_rate_phase);
    host_write(`ADDR_SILENCER_COMPLETION_STEPS_INTENSITY, exp.completion_steps_intensity);
    host_write(`ADDR_SILENCER_COMPLETION_STEPS_PHASE, exp.completion_steps_phase);
endtask

task automatic test_reset_defaults();
    silencer_settings_t exp_sil;
    pwe_settings_t      exp_pwe;
    exp_sil.update                     = 1'b0;
    exp_sil.mode                       = `SILENCER_MODE_DEFAULT;
    exp_sil.update_rate_intensity      = `SILENCER_UPDATE_RATE_INTENSITY_DEFAULT;
    exp_sil.update_rate_phase          = `SILENCER_UPDATE_RATE_PHASE_DEFAULT;
    exp_sil.completion_steps_intensity = `SILENCER_COMPLETION_STEPS_INTENSITY_DEFAULT;
    exp_sil.completion_steps_phase     = `SILENCER_COMPLETION_STEPS_PHASE_DEFAULT;
    exp_pwe.update                     = 1'b0;
    exp_pwe.full_width_start           = `PWE_FULL_WIDTH_START_DEFAULT;
    @(negedge CLK);
    check_silencer("test_reset_defaults", exp_sil, silencer);
    check_pwe("test_reset_defaults", exp_pwe, pwe);
    check_outputs("test_reset_defaults", 1'b0, 4'h0);
endtask

task automatic test_version();
    reg_data_t rdata;
    repeat (2) @(negedge CLK); // Version writes land first
    host_read(`ADDR_VERSION_NUM_MAJOR, rdata);
    check_data("test_version", {8'h00, `VERSION_NUM_MAJOR}, rdata);
    host_read(`ADDR_VERSION_NUM_MINOR, rdata);
    check_data("test_version", {8'h00, `VERSION_NUM_MINOR}, rdata);
endtask

task automatic test_silencer_load();
    silencer_settings_t exp_sil;
    reg_data_t          rdata;
    bit                 seen;
    bit                 other_seen;
    write_silencer_fields(exp_sil);
    host_write(`ADDR_CTL_FLAG, reg_data_t'(1) << `CTL_FLAG_BIT_SILENCER_SET);
    wait_update_pulse(1'b0, "test_silencer_load", seen, other_seen);
    if (other_seen) begin
        error_count++;
        $display("ERROR: test_silencer_load: pulse width encoder update came without its flag");
    end
    if (seen) begin
        check_silencer("test_silencer_load", exp_sil, silencer);
        host_read(`ADDR_CTL_FLAG, rdata);
        check_data("test_silencer_load", 16'h0000, rdata); // Set bit cleared by write-back
    end
endtask

task automatic test_both_groups();
    silencer_settings_t exp_sil;
    pwe_settings_t      exp_pwe;
    bit                 sil_seen;
    bit                 pwe_seen;
    bit                 pwe_first;
    bit                 sil_again;
    write_silencer_fields(exp_sil);
    exp_pwe.update           = 1'b1;
    exp_pwe.full_width_start = random_word();
    host_write(`ADDR_PULSE_WIDTH_ENCODER_FULL_WIDTH_START, exp_pwe.full_width_start);
    host_write(`ADDR_CTL_FLAG, (reg_data_t'(1) << `CTL_FLAG_BIT_SILENCER_SET) |
                               (reg_data_t'(1) << `CTL_FLAG_BIT_PULSE_WIDTH_ENCODER_SET));
    wait_update_pulse(1'b0, "test_both_groups", sil_seen, pwe_first);
    if (pwe_first) begin
        error_count++;
        $display("ERROR: test_both_groups: pulse width encoder update came before silencer");
    end
    if (sil_seen) begin
        check_silencer("test_both_groups", exp_sil, silencer);
    end
    wait_update_pulse(1'b1, "test_both_groups", pwe_seen, sil_again);
    if (sil_again) begin
        error_count++;
        $display("ERROR: test_both_groups: silencer update came again before pulse width encoder");
    end
    if (pwe_seen) begin
        check_pwe("test_both_groups", exp_pwe, pwe);
    end
    exp_sil.update = 1'b0;
    exp_pwe.update = 1'b0;
    @(negedge CLK);
    check_silencer("test_both_groups", exp_sil, silencer); // Values held after the pulses
    check_pwe("test_both_groups", exp_pwe, pwe);
endtask

task automatic test_flags_and_state();
    logic       exp_fan;
    logic [3:0] exp_gpio;
    reg_data_t  flag_word;
    reg_data_t  rdata;
    int         waited;
    exp_fan   = 1'($urandom());
    exp_gpio  = 4'($urandom_range(15, 1));
    flag_word = '0;
    flag_word[`CTL_FLAG_BIT_FORCE_FAN] = exp_fan;
    flag_word[`CTL_FLAG_BIT_GPIO_IN_0] = exp_gpio[0];
    flag_word[`CTL_FLAG_BIT_GPIO_IN_1] = exp_gpio[1];
    flag_word[`CTL_FLAG_BIT_GPIO_IN_2] = exp_gpio[2];
    flag_word[`CTL_FLAG_BIT_GPIO_IN_3] = exp_gpio[3];
    thermo = 1'b1;
    host_write(`ADDR_CTL_FLAG, flag_word);
    waited = 0;
    while ((force_fan !== exp_fan || gpio_in !== exp_gpio) && waited < FLAG_WAIT_CYCLES) begin
        @(negedge CLK);
        waited++;
    end
    check_outputs("test_flags_and_state", exp_fan, exp_gpio);
    host_read(`ADDR_FPGA_STATE, rdata);
    check_data("test_flags_and_state", {15'd0, 1'b1}, rdata); // THERMO in bit 0
endtask

`endif

// ==== dv/controller_tb.sv ====
`include "ctl_consts.svh"

module controller_tb
    import ctl_pkg::*;
();

    localparam int RESET_CYCLES      = 5;
    localparam int PULSE_WAIT_CYCLES = 200;
    localparam int FLAG_WAIT_CYCLES  = 50;
    localparam int TIMEOUT_CYCLES    = 3000; // All waits together stay below 1000 cycles
    localparam int RANDOM_SEED       = 31799;

    logic               CLK;
    logic               rst;
    logic               thermo;
    host_req_t          host_req;
    reg_data_t          host_rdata;
    logic               force_fan;
    logic [3:0]         gpio_in;
    silencer_settings_t silencer;
    pwe_settings_t      pwe;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    controller_top controller_top_inst (
        .CLK        (CLK),
        .rst        (rst),
        .thermo     (thermo),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .force_fan  (force_fan),
        .gpio_in    (gpio_in),
        .silencer   (silencer),
        .pwe        (pwe)
    );

    `include "controller_tb_tasks.svh"

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped: no result after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        CLK      = 1'b0;
        rst      = 1'b1;
        thermo   = 1'b0;
        host_req = '0;
        void'($urandom(RANDOM_SEED));
        @(negedge CLK);
        host_write(`ADDR_CTL_FLAG, 16'h0000); // Flag word starts undefined
        repeat (RESET_CYCLES - 2) @(negedge CLK);
        rst = 1'b0;

        test_reset_defaults();
        test_version();
        test_silencer_load();
        test_both_groups();
        test_flags_and_state();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/controller_top.sv ====
module controller_top
    import ctl_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  logic               thermo,
    input  host_req_t          host_req,
    output reg_data_t          host_rdata,
    output logic               force_fan,
    output logic [3:0]         gpio_in,
    output silencer_settings_t silencer,
    output pwe_settings_t      pwe
);

    ctl_req_t ctl_req;
    ctl_rsp_t ctl_rsp; // Shared by sequencer and loader

    cnt_reg_ram cnt_reg_ram_inst (
        .CLK        (CLK),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .ctl_req    (ctl_req),
        .ctl_rsp    (ctl_rsp)
    );

    ctl_sequencer ctl_sequencer_inst (
        .CLK       (CLK),
        .rst       (rst),
        .thermo    (thermo),
        .ctl_rsp   (ctl_rsp),
        .ctl_req   (ctl_req),
        .force_fan (force_fan),
        .gpio_in   (gpio_in)
    );

    settings_loader settings_loader_inst (
        .CLK      (CLK),
        .rst      (rst),
        .ctl_rsp  (ctl_rsp),
        .silencer (silencer),
        .pwe      (pwe)
    );

endmodule

// ==== hw/settings_loader.sv ====
`include "ctl_consts.svh"

module settings_loader
    import ctl_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  ctl_rsp_t           ctl_rsp,
    output silencer_settings_t silencer,
    output pwe_settings_t      pwe
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            silencer.update                     <= 1'b0;
            silencer.mode                       <= `SILENCER_MODE_DEFAULT;
            silencer.update_rate_intensity      <= `SILENCER_UPDATE_RATE_INTENSITY_DEFAULT;
            silencer.update_rate_phase          <= `SILENCER_UPDATE_RATE_PHASE_DEFAULT;
            silencer.completion_steps_intensity <= `SILENCER_COMPLETION_STEPS_INTENSITY_DEFAULT;
            silencer.completion_steps_phase     <= `SILENCER_COMPLETION_STEPS_PHASE_DEFAULT;
            pwe.update                          <= 1'b0;
            pwe.full_width_start                <= `PWE_FULL_WIDTH_START_DEFAULT;
        end else begin
            silencer.update <= 1'b0; // Single cycle pulses
            pwe.update      <= 1'b0;
            if (ctl_rsp.valid) begin
                case (ctl_rsp.tag)
                    FIELD_SIL_MODE: begin
                        silencer.mode <= ctl_rsp.data[0];
                    end
                    FIELD_SIL_UPDATE_RATE_INTENSITY: begin
                        silencer.update_rate_intensity <= ctl_rsp.data;
                    end
                    FIELD_SIL_UPDATE_RATE_PHASE: begin
                        silencer.update_rate_phase <= ctl_rsp.data;
                    end
                    FIELD_SIL_COMPLETION_STEPS_INTENSITY: begin
                        silencer.completion_steps_intensity <= ctl_rsp.data;
                    end
                    FIELD_SIL_COMPLETION_STEPS_PHASE: begin
                        silencer.completion_steps_phase <= ctl_rsp.data;
                        silencer.update                 <= 1'b1; // Last silencer field
                    end
                    FIELD_PWE_FULL_WIDTH_START: begin
                        pwe.full_width_start <= ctl_rsp.data;
                        pwe.update           <= 1'b1;
                    end
                    default: begin
                        // Flag word and untagged responses belong to the sequencer
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/ctl_sequencer.sv ====
`include "ctl_consts.svh"

module ctl_sequencer
    import ctl_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       thermo,
    input  ctl_rsp_t   ctl_rsp,
    output ctl_req_t   ctl_req,
    output logic       force_fan,
    output logic [3:0] gpio_in
);

    localparam ctl_flags_t sil_set_mask = 16'(1) << `CTL_FLAG_BIT_SILENCER_SET;
    localparam ctl_flags_t pwe_set_mask = 16'(1) << `CTL_FLAG_BIT_PULSE_WIDTH_ENCODER_SET;

    seq_state_t state;
    ctl_flags_t flags;
    ctl_flags_t rsp_flags;
    reg_data_t  fpga_state;
    logic       flag_rsp;

    function automatic ctl_req_t rd_req(input reg_addr_t addr, input ctl_field_t tag);
        ctl_req_t req;
        req.we    = 1'b0;
        req.addr  = addr;
        req.din   = '0;
        req.tag   = tag;
        req.valid = 1'b1;
        return req;
    endfunction

    function automatic ctl_req_t wr_req(input reg_addr_t addr, input reg_data_t din);
        ctl_req_t req;
        req.we    = 1'b1;
        req.addr  = addr;
        req.din   = din;
        req.tag   = FIELD_NONE;
        req.valid = 1'b1;
        return req;
    endfunction

    assign rsp_flags  = ctl_rsp.data;
    assign flag_rsp   = ctl_rsp.valid && (ctl_rsp.tag == FIELD_CTL_FLAG);
    assign fpga_state = {15'd0, thermo}; // THERMO in bit 0

    assign force_fan = flags[`CTL_FLAG_BIT_FORCE_FAN];
    assign gpio_in   = {flags[`CTL_FLAG_BIT_GPIO_IN_3], flags[`CTL_FLAG_BIT_GPIO_IN_2],
                        flags[`CTL_FLAG_BIT_GPIO_IN_1], flags[`CTL_FLAG_BIT_GPIO_IN_0]};

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= ST_VER_MAJOR;
            ctl_req <= '0;
            flags   <= '0;
        end else begin
            ctl_req.valid <= 1'b0;
            case (state)
                ST_VER_MAJOR: begin
                    ctl_req <= wr_req(`ADDR_VERSION_NUM_MAJOR, {8'd0, `VERSION_NUM_MAJOR});
                    state   <= ST_VER_MINOR;
                end
                ST_VER_MINOR: begin
                    ctl_req <= wr_req(`ADDR_VERSION_NUM_MINOR, {8'd0, `VERSION_NUM_MINOR});
                    state   <= ST_POLL;
                end
                ST_POLL: begin
                    ctl_req <= rd_req(`ADDR_CTL_FLAG, FIELD_CTL_FLAG);
                    state   <= ST_POLL_WAIT;
                end
                ST_POLL_WAIT: begin
                    if (flag_rsp) begin // Arrives two cycles after the poll read
                        ctl_req <= wr_req(`ADDR_FPGA_STATE, fpga_state);
                        if (rsp_flags[`CTL_FLAG_BIT_SILENCER_SET]) begin
                            flags <= rsp_flags & ~sil_set_mask;
                            state <= ST_SIL_MODE;
                        end else if (rsp_flags[`CTL_FLAG_BIT_PULSE_WIDTH_ENCODER_SET]) begin
                            flags <= rsp_flags & ~pwe_set_mask;
                            state <= ST_PWE_FWS;
                        end else begin
                            flags <= rsp_flags;
                            state <= ST_POLL;
                        end
                    end
                end
                ST_SIL_MODE: begin
                    ctl_req <= rd_req(`ADDR_SILENCER_MODE, FIELD_SIL_MODE);
                    state   <= ST_SIL_RATE_I;
                end
                ST_SIL_RATE_I: begin
                    ctl_req <= rd_req(`ADDR_SILENCER_UPDATE_RATE_INTENSITY,
                                      FIELD_SIL_UPDATE_RATE_INTENSITY);
                    state   <= ST_SIL_RATE_P;
                end
                ST_SIL_RATE_P: begin
                    ctl_req <= rd_req(`ADDR_SILENCER_UPDATE_RATE_PHASE,
                                      FIELD_SIL_UPDATE_RATE_PHASE);
                    state   <= ST_SIL_STEPS_I;
                end
                ST_SIL_STEPS_I: begin
                    ctl_req <= rd_req(`ADDR_SILENCER_COMPLETION_STEPS_INTENSITY,
                                      FIELD_SIL_COMPLETION_STEPS_INTENSITY);
                    state   <= ST_SIL_STEPS_P;
                end
                ST_SIL_STEPS_P: begin
                    ctl_req <= rd_req(`ADDR_SILENCER_COMPLETION_STEPS_PHASE,
                                      FIELD_SIL_COMPLETION_STEPS_PHASE);
                    state   <= ST_FLAG_WB;
                end
                ST_PWE_FWS: begin
                    ctl_req <= rd_req(`ADDR_PULSE_WIDTH_ENCODER_FULL_WIDTH_START,
                                      FIELD_PWE_FULL_WIDTH_START);
                    state   <= ST_FLAG_WB;
                end
                ST_FLAG_WB: begin
                    ctl_req <= wr_req(`ADDR_CTL_FLAG, flags); // Set bit already cleared
                    state   <= ST_STATE_WB;
                end
                ST_STATE_WB: begin
                    ctl_req <= wr_req(`ADDR_FPGA_STATE, fpga_state);
                    state   <= ST_POLL;
                end
                default: state <= ST_POLL;
            endcase
        end
    end

endmodule

// ==== hw/cnt_reg_ram.sv ====
module cnt_reg_ram
    import ctl_pkg::*;
(
    input  logic      CLK,
    input  host_req_t host_req,
    output reg_data_t host_rdata,
    input  ctl_req_t  ctl_req,
    output ctl_rsp_t  ctl_rsp
);

    reg_data_t mem [256];

    reg_addr_t  host_addr_q;
    reg_addr_t  ctl_addr_q;
    ctl_field_t ctl_tag_q;
    logic       ctl_rd_q;

    always_ff @(posedge CLK) begin
        if (host_req.valid && host_req.we) begin
            mem[host_req.addr] <= host_req.data;
        end
        if (ctl_req.valid && ctl_req.we) begin
            mem[ctl_req.addr] <= ctl_req.din; // Later write wins on a clash
        end
    end

    // Host port registers the address then the data
    always_ff @(posedge CLK) begin
        if (host_req.valid && !host_req.we) begin
            host_addr_q <= host_req.addr;
        end
        host_rdata <= mem[host_addr_q];
    end

    // Tag and valid travel with the controller address
    always_ff @(posedge CLK) begin
        ctl_addr_q   <= ctl_req.addr;
        ctl_tag_q    <= ctl_req.tag;
        ctl_rd_q     <= ctl_req.valid && !ctl_req.we; // Only reads answer
        ctl_rsp.valid <= ctl_rd_q;
        ctl_rsp.tag   <= ctl_tag_q;
        ctl_rsp.data  <= mem[ctl_addr_q];
    end

endmodule

// ==== hw/ctl_pkg.sv ====
package ctl_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [15:0] ctl_flags_t;

    // Names the register a read response belongs to
    typedef enum logic [2:0] {
        FIELD_NONE                           = 3'd0,
        FIELD_CTL_FLAG                       = 3'd1,
        FIELD_SIL_MODE                       = 3'd2,
        FIELD_SIL_UPDATE_RATE_INTENSITY      = 3'd3,
        FIELD_SIL_UPDATE_RATE_PHASE          = 3'd4,
        FIELD_SIL_COMPLETION_STEPS_INTENSITY = 3'd5,
        FIELD_SIL_COMPLETION_STEPS_PHASE     = 3'd6,
        FIELD_PWE_FULL_WIDTH_START           = 3'd7
    } ctl_field_t;

    typedef enum logic [3:0] {
        ST_VER_MAJOR,
        ST_VER_MINOR,
        ST_POLL,
        ST_POLL_WAIT,
        ST_SIL_MODE,
        ST_SIL_RATE_I,
        ST_SIL_RATE_P,
        ST_SIL_STEPS_I,
        ST_SIL_STEPS_P,
        ST_PWE_FWS,
        ST_FLAG_WB,
        ST_STATE_WB
    } seq_state_t;

    typedef struct packed {
        logic       we;
        reg_addr_t  addr;
        reg_data_t  din;
        ctl_field_t tag;
        logic       valid;
    } ctl_req_t;

    typedef struct packed {
        logic       valid;
        ctl_field_t tag;
        reg_data_t  data;
    } ctl_rsp_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t addr;
        reg_data_t data;
    } host_req_t;

    typedef struct packed {
        logic      update;
        logic      mode;
        reg_data_t update_rate_intensity;
        reg_data_t update_rate_phase;
        reg_data_t completion_steps_intensity;
        reg_data_t completion_steps_phase;
    } silencer_settings_t;

    typedef struct packed {
        logic      update;
        reg_data_t full_width_start;
    } pwe_settings_t;

endpackage

// ==== hw/ctl_consts.svh ====
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

// Register map of the control memory
`define ADDR_CTL_FLAG                              8'h00
`define ADDR_FPGA_STATE                            8'h01
`define ADDR_VERSION_NUM_MAJOR                     8'h02
`define ADDR_VERSION_NUM_MINOR                     8'h03
`define ADDR_SILENCER_MODE                         8'h40
`define ADDR_SILENCER_UPDATE_RATE_INTENSITY        8'h41
`define ADDR_SILENCER_UPDATE_RATE_PHASE            8'h42
`define ADDR_SILENCER_COMPLETION_STEPS_INTENSITY   8'h43
`define ADDR_SILENCER_COMPLETION_STEPS_PHASE       8'h44
`define ADDR_PULSE_WIDTH_ENCODER_FULL_WIDTH_START  8'h50

// Bit positions in the control flag word
`define CTL_FLAG_BIT_SILENCER_SET                  2
`define CTL_FLAG_BIT_PULSE_WIDTH_ENCODER_SET       3
`define CTL_FLAG_BIT_FORCE_FAN                     8
`define CTL_FLAG_BIT_GPIO_IN_0                     9
`define CTL_FLAG_BIT_GPIO_IN_1                     10
`define CTL_FLAG_BIT_GPIO_IN_2                     11
`define CTL_FLAG_BIT_GPIO_IN_3                     12

// Firmware version
`define VERSION_NUM_MAJOR                          8'h0A
`define VERSION_NUM_MINOR                          8'h01

// Cycles from request to response on either memory port
`define RAM_RD_LATENCY                             2

// Silencer mode encodings
`define SILENCER_MODE_FIXED_UPDATE_RATE            1'b0
`define SILENCER_MODE_FIXED_COMPLETION_STEPS       1'b1

// Settings after reset
`define SILENCER_MODE_DEFAULT                      `SILENCER_MODE_FIXED_COMPLETION_STEPS
`define SILENCER_UPDATE_RATE_INTENSITY_DEFAULT     16'd256
`define SILENCER_UPDATE_RATE_PHASE_DEFAULT         16'd256
`define SILENCER_COMPLETION_STEPS_INTENSITY_DEFAULT 16'd10
`define SILENCER_COMPLETION_STEPS_PHASE_DEFAULT    16'd40
`define PWE_FULL_WIDTH_START_DEFAULT               16'd65025

`endif
